// ==== logic/up_pkg.sv ====
package up_pkg;

   localparam int WORD_W = 8;
   localparam int NIB_W  = 4;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [NIB_W-1:0]  nibble_t;

   localparam word_t PC_RESET  = 8'h08;   // Byte 4, high nibble
   localparam word_t SP_RESET  = 8'hFF;
   localparam int    BOOT_REGS = 4;

   typedef enum logic [3:0] {
      OP_ADD  = 4'b0000, OP_SUB   = 4'b0001, OP_MUL = 4'b0010, OP_NAND = 4'b0011,
      OP_SW01 = 4'b0100, OP_SW12  = 4'b0101, OP_SW23 = 4'b0110, OP_BE  = 4'b0111,
      OP_POPC = 4'b1000, OP_PUSHC = 4'b1001, OP_POP = 4'b1010, OP_PUSH = 4'b1011,
      OP_LDW  = 4'b1100, OP_STW   = 4'b1101, OP_REF = 4'b1110, OP_INT  = 4'b1111
   } opcode_t;

   // Arithmetic and swap codes line up with the low opcode bits
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_MUL, ALU_NAND,
      ALU_XOR01, ALU_XOR12, ALU_XOR23, ALU_ZERO, ALU_MEM
   } alu_op_t;

   typedef enum logic [2:0] {ADDR_BOOT, ADDR_FETCH, ADDR_SP, ADDR_SP_INC, ADDR_R3} addr_sel_t;

   typedef enum logic [2:0] {PTR_HOLD, PTR_PC_INC, PTR_PC_LOAD_R3, PTR_SP_INC, PTR_SP_DEC} ptr_op_t;

   typedef struct packed {
      alu_op_t   alu_op;
      logic [1:0] rb_sel;
      logic      rb_we;
      ptr_op_t   ptr_op;
      logic      ir_we;
      logic      mem_start;
      logic      mem_write;
      addr_sel_t addr_sel;
      logic [1:0] boot_idx;
      logic      wdata_from_r2;
   } ctrl_word_t;

   typedef struct packed {
      word_t   pc;
      word_t   sp;
      nibble_t ir;
      logic    pc_odd;
   } ptr_bus_t;

   typedef struct packed {
      word_t r2;
      word_t r3;
   } reg_bus_t;

   localparam ctrl_word_t CTRL_IDLE = '{
      alu_op: ALU_ZERO, rb_sel: 2'd0, rb_we: 1'b0, ptr_op: PTR_HOLD, ir_we: 1'b0,
      mem_start: 1'b0, mem_write: 1'b0, addr_sel: ADDR_BOOT, boot_idx: 2'd0,
      wdata_from_r2: 1'b0
   };

endpackage

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ns

module reg_bank (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::ctrl_word_t ctrl,
   input  up_pkg::word_t      rd_data,
   output up_pkg::reg_bus_t   regs,
   output logic               eq
);
   import up_pkg::*;

   word_t r [0:3];
   word_t result;

   always_comb begin
      case (ctrl.alu_op)
         ALU_ADD:   result = r[1] + r[2];
         ALU_SUB:   result = r[1] - r[2];
         ALU_MUL:   result = r[1] * r[2];    // Upper product bits are dropped
         ALU_NAND:  result = ~(r[1] & r[2]);
         ALU_XOR01: result = r[0] ^ r[1];
         ALU_XOR12: result = r[1] ^ r[2];
         ALU_XOR23: result = r[2] ^ r[3];
         ALU_MEM:   result = rd_data;
         default:   result = '0;
      endcase
   end

   assign eq   = (r[1] == r[2]);
   assign regs = '{r2: r[2], r3: r[3]};

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         r[0] <= '0;
         r[1] <= '0;
         r[2] <= '0;
         r[3] <= '0;
      end else if (ctrl.rb_we) begin
         r[ctrl.rb_sel] <= result;
      end
   end

endmodule

// ==== logic/ptr_unit.sv ====
`timescale 1ns/1ns

module ptr_unit (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::ctrl_word_t ctrl,
   input  up_pkg::word_t      rd_data,
   input  up_pkg::word_t      r3,
   output up_pkg::ptr_bus_t   ptr
);
   import up_pkg::*;

   word_t   pc;   // Counts nibbles
   word_t   sp;
   nibble_t ir;

   assign ptr = '{pc: pc, sp: sp, ir: ir, pc_odd: pc[0]};

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RESET;
         sp <= SP_RESET;
         ir <= '0;
      end else begin
         case (ctrl.ptr_op)
            PTR_PC_INC:     pc <= pc + 8'd1;
            PTR_PC_LOAD_R3: pc <= r3;
            PTR_SP_INC:     sp <= sp + 8'd1;
            PTR_SP_DEC:     sp <= sp - 8'd1;
            default: ;
         endcase

         // High nibble runs first
         if (ctrl.ir_we)
            ir <= ptr.pc_odd ? rd_data[3:0] : rd_data[7:4];
      end
   end

endmodule

// ==== logic/mem_port.sv ====
`timescale 1ns/1ns

module mem_port (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::ctrl_word_t ctrl,
   input  up_pkg::ptr_bus_t   ptr,
   input  up_pkg::reg_bus_t   regs,
   output logic               mem_req,
   output logic               mem_write,
   output up_pkg::word_t      mem_addr,
   output up_pkg::word_t      mem_wdata,
   input  logic               mem_ack,
   input  up_pkg::word_t      mem_rdata,
   output up_pkg::word_t      rd_data,
   output logic               mem_done
);
   import up_pkg::*;

   typedef enum logic [1:0] {P_IDLE, P_REQ, P_ACK_LOW} port_state_t;

   port_state_t st;
   word_t       next_addr;
   logic        launch;

   always_comb begin
      case (ctrl.addr_sel)
         ADDR_FETCH:  next_addr = {1'b0, ptr.pc[7:1]};   // Two instructions per byte
         ADDR_SP:     next_addr = ptr.sp;
         ADDR_SP_INC: next_addr = ptr.sp + 8'd1;
         ADDR_R3:     next_addr = regs.r3;
         default:     next_addr = {6'd0, ctrl.boot_idx};
      endcase
   end

   assign launch   = (st == P_IDLE) && ctrl.mem_start;
   assign mem_done = (st == P_ACK_LOW) && !mem_ack;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         st        <= P_IDLE;
         mem_req   <= 1'b0;
         mem_write <= 1'b0;
      end else begin
         case (st)
            P_IDLE: if (launch) begin
               mem_req   <= 1'b1;
               mem_write <= ctrl.mem_write;
               st        <= P_REQ;
            end
            P_REQ: if (mem_ack) begin
               mem_req   <= 1'b0;
               mem_write <= 1'b0;
               st        <= P_ACK_LOW;
            end
            P_ACK_LOW: if (!mem_ack) st <= P_IDLE;   // Next request may follow
            default: st <= P_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (launch) begin
         mem_addr  <= next_addr;
         mem_wdata <= ctrl.wdata_from_r2 ? regs.r2 : '0;
      end
      if (st == P_REQ && mem_ack && !mem_write)
         rd_data <= mem_rdata;
   end

endmodule

// ==== logic/seq_control.sv ====
`timescale 1ns/1ns

module seq_control (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::ptr_bus_t   ptr,
   input  logic               eq,
   input  logic               mem_done,
   output up_pkg::ctrl_word_t ctrl
);
   import up_pkg::*;

   typedef enum logic [2:0] {S_BOOT, S_FETCH, S_DECODE, S_EX1, S_EX2, S_EX3} state_t;

   state_t     state;
   state_t     state_n;
   logic       busy;      // An access is in flight on the memory port
   logic [1:0] boot_cnt;
   logic       go;
   opcode_t    op;
   logic [1:0] pair_lo;

   assign go      = busy & mem_done;
   assign op      = opcode_t'(ptr.ir);
   assign pair_lo = ptr.ir[1:0];   // Lower register of the swapped pair

   always_comb begin
      ctrl    = CTRL_IDLE;
      state_n = state;
      case (state)
         S_BOOT: begin
            ctrl.addr_sel  = ADDR_BOOT;
            ctrl.boot_idx  = boot_cnt;
            ctrl.mem_start = !busy;
            ctrl.alu_op    = ALU_MEM;
            ctrl.rb_sel    = boot_cnt;
            ctrl.rb_we     = go;
            if (go && boot_cnt == 2'(BOOT_REGS - 1))
               state_n = S_FETCH;
         end
         S_FETCH: begin
            ctrl.addr_sel  = ADDR_FETCH;
            ctrl.mem_start = !busy;
            if (go)
               state_n = S_DECODE;
         end
         S_DECODE: begin
            ctrl.ir_we  = 1'b1;         // Nibble is picked from the old pc
            ctrl.ptr_op = PTR_PC_INC;
            state_n     = S_EX1;
         end
         S_EX1: begin
            state_n = S_FETCH;
            case (op)
               OP_ADD, OP_SUB, OP_MUL, OP_NAND: begin
                  ctrl.alu_op = alu_op_t'({2'b00, pair_lo});
                  ctrl.rb_sel = 2'd0;
                  ctrl.rb_we  = 1'b1;
               end
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.alu_op = alu_op_t'({2'b01, pair_lo});
                  ctrl.rb_sel = pair_lo;
                  ctrl.rb_we  = 1'b1;
                  state_n     = S_EX2;
               end
               OP_BE: begin
                  if (eq)
                     ctrl.ptr_op = PTR_PC_LOAD_R3;
               end
               OP_PUSH: begin
                  ctrl.addr_sel      = ADDR_SP;
                  ctrl.mem_write     = 1'b1;
                  ctrl.wdata_from_r2 = 1'b1;
                  ctrl.mem_start     = !busy;
                  state_n            = go ? S_EX2 : S_EX1;
               end
               OP_POP, OP_LDW, OP_REF: begin
                  // Read into r2, or into r0 for REF
                  ctrl.addr_sel  = (op == OP_POP) ? ADDR_SP_INC : (op == OP_LDW) ? ADDR_R3 : ADDR_BOOT;
                  ctrl.mem_start = !busy;
                  ctrl.alu_op    = ALU_MEM;
                  ctrl.rb_sel    = (op == OP_REF) ? 2'd0 : 2'd2;
                  ctrl.rb_we     = go;
                  if (go && op == OP_POP)
                     ctrl.ptr_op = PTR_SP_INC;
                  state_n = go ? S_FETCH : S_EX1;
               end
               OP_STW: begin
                  ctrl.addr_sel      = ADDR_R3;
                  ctrl.mem_write     = 1'b1;
                  ctrl.wdata_from_r2 = 1'b1;
                  ctrl.mem_start     = !busy;
                  state_n            = go ? S_FETCH : S_EX1;
               end
               OP_POPC, OP_PUSHC, OP_INT: state_n = S_FETCH;   // No-ops
               default: state_n = S_FETCH;
            endcase
         end
         S_EX2: begin
            state_n = S_FETCH;
            if (op == OP_SW01 || op == OP_SW12 || op == OP_SW23) begin
               ctrl.alu_op = alu_op_t'({2'b01, pair_lo});
               ctrl.rb_sel = pair_lo + 2'd1;
               ctrl.rb_we  = 1'b1;
               state_n     = S_EX3;
            end else if (op == OP_PUSH) begin
               ctrl.ptr_op = PTR_SP_DEC;
            end
         end
         S_EX3: begin
            ctrl.alu_op = alu_op_t'({2'b01, pair_lo});
            ctrl.rb_sel = pair_lo;
            ctrl.rb_we  = 1'b1;
            state_n     = S_FETCH;
         end
         default: state_n = S_FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state    <= S_BOOT;
         busy     <= 1'b0;
         boot_cnt <= 2'd0;
      end else begin
         state <= state_n;
         if (ctrl.mem_start)
            busy <= 1'b1;
         else if (go)
            busy <= 1'b0;
         if (state == S_BOOT && go)
            boot_cnt <= boot_cnt + 2'd1;
      end
   end

endmodule

// ==== logic/up_core.sv ====
`timescale 1ns/1ns

module up_core (
   input  logic          clk,
   input  logic          nRst,
   output logic          mem_req,
   output logic          mem_write,
   output up_pkg::word_t mem_addr,
   output up_pkg::word_t mem_wdata,
   input  logic          mem_ack,
   input  up_pkg::word_t mem_rdata
);
   import up_pkg::*;

   ctrl_word_t ctrl;
   ptr_bus_t   ptr;
   reg_bus_t   regs;
   word_t      rd_data;
   logic       eq;
   logic       mem_done;

   seq_control u_seq (
      .clk      (clk),
      .nRst     (nRst),
      .ptr      (ptr),
      .eq       (eq),
      .mem_done (mem_done),
      .ctrl     (ctrl)
   );

   reg_bank u_regs (
      .clk     (clk),
      .nRst    (nRst),
      .ctrl    (ctrl),
      .rd_data (rd_data),
      .regs    (regs),
      .eq      (eq)
   );

   ptr_unit u_ptr (
      .clk     (clk),
      .nRst    (nRst),
      .ctrl    (ctrl),
      .rd_data (rd_data),
      .r3      (regs.r3),
      .ptr     (ptr)
   );

   mem_port u_port (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .ptr       (ptr),
      .regs      (regs),
      .mem_req   (mem_req),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .rd_data   (rd_data),
      .mem_done  (mem_done)
   );

endmodule

// ==== testbench/up_core_props.sv ====
`timescale 1ns/1ns

module up_core_props (
   input logic          clk,
   input logic          nRst,
   input logic          mem_req,
   input logic          mem_ack,
   input up_pkg::word_t mem_addr
);
   int fail_count = 0;

   req_held: assert property (@(posedge clk) disable iff (!nRst)
      mem_req && !mem_ack |=> mem_req)
   else begin
      $error("mem_req dropped before mem_ack was seen");
      fail_count++;
   end

   addr_stable: assert property (@(posedge clk) disable iff (!nRst)
      mem_req && $past(mem_req) |-> mem_addr == $past(mem_addr))
   else begin
      $error("mem_addr changed while mem_req was high");
      fail_count++;
   end

   // The ack from the last access has to be gone first
   no_early_req: assert property (@(posedge clk) disable iff (!nRst)
      $rose(mem_req) |-> !$past(mem_ack))
   else begin
      $error("mem_req rose while mem_ack was still high");
      fail_count++;
   end

endmodule

bind mem_port up_core_props props (
   .clk      (clk),
   .nRst     (nRst),
   .mem_req  (mem_req),
   .mem_ack  (mem_ack),
   .mem_addr (mem_addr)
);

// ==== include/up_tb_tasks.svh ====
`ifndef UP_TB_TASKS_SVH
`define UP_TB_TASKS_SVH

function automatic word_t fill_byte(word_t a);
   return (a * 8'd7) ^ 8'hC3;   // Every address bit changes the byte
endfunction

task automatic stop_run();
   $display("CHECKS FAILED");
   $fatal(1, "Run stopped");
endtask

task automatic compare_value(string name, word_t got, word_t exp);
   if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
   end
endtask

task automatic await_accesses(int count, int limit);
   int cycles;
   cycles = 0;
   while (acc_addr.size() < count) begin
      if (cycles >= limit) begin
         $display("Timed out after %0d cycles waiting for %0d memory accesses", limit, count);
         stop_run();
      end else begin
         @(posedge clk);
         cycles++;
      end
   end
endtask

task automatic await_writes(int count, int limit);
   int cycles;
   cycles = 0;
   while (wr_addr.size() < count) begin
      if (cycles >= limit) begin
         $display("Timed out after %0d cycles waiting for %0d memory writes", limit, count);
         stop_run();
      end else begin
         @(posedge clk);
         cycles++;
      end
   end
endtask

// Memory is refilled while the core is held in reset
task automatic hold_reset();
   @(negedge clk);
   nRst <= 1'b0;
   @(posedge clk);
   for (int a = 0; a < 256; a++)
      mem[a] = fill_byte(word_t'(a));
   acc_addr.delete();
   acc_write.delete();
   wr_addr.delete();
   wr_data.delete();
endtask

task automatic release_reset();
   repeat (5) @(negedge clk);
   nRst <= 1'b1;
endtask

// Bytes 0 to 3 are the boot registers and the program starts at byte 4
task automatic load_program(word_t r0, word_t r1, word_t r2, word_t r3,
                            word_t b4, word_t b5, word_t b6);
   mem[0] = r0;
   mem[1] = r1;
   mem[2] = r2;
   mem[3] = r3;
   mem[4] = b4;
   mem[5] = b5;
   mem[6] = b6;
endtask

task automatic boot_order();
   hold_reset();
   load_program(8'h11, 8'h22, 8'h33, 8'h44, 8'hFF, 8'hFF, 8'hFF);
   release_reset();
   compare_value("mem_req", word_t'(mem_req), 8'h00);   // Still low out of reset
   await_accesses(5, 100);
   for (int i = 0; i < 5; i++) begin
      compare_value("mem_addr", acc_addr[i], word_t'(i));
      compare_value("mem_write", word_t'(acc_write[i]), 8'h00);
   end
endtask

// Op, SW01, SW12, STW moves the result from r0 to r2 and stores it at r3
task automatic arith_op(logic [1:0] op, word_t a, word_t b);
   word_t exp;
   case (op)
      2'd0:    exp = a + b;
      2'd1:    exp = a - b;
      2'd2:    exp = a * b;
      default: exp = ~(a & b);
   endcase
   hold_reset();
   load_program(8'h5A, a, b, 8'h40, {2'b00, op, 4'h4}, 8'h5D, 8'hFF);
   release_reset();
   await_writes(1, 500);
   compare_value("mem_addr", wr_addr[0], 8'h40);
   compare_value("mem_wdata", wr_data[0], exp);
endtask

// PUSH, SW12, PUSH, SW12, POP, STW
task automatic stack_ops(word_t a, word_t b);
   hold_reset();
   load_program(8'h00, a, b, 8'h40, 8'hB5, 8'hB5, 8'hAD);
   release_reset();
   await_writes(3, 800);
   compare_value("mem_addr", wr_addr[0], 8'hFF);
   compare_value("mem_wdata", wr_data[0], b);
   compare_value("mem_addr", wr_addr[1], 8'hFE);
   compare_value("mem_wdata", wr_data[1], a);
   compare_value("mem_addr", wr_addr[2], 8'h40);
   compare_value("mem_wdata", wr_data[2], a);    // Popped from FE
endtask

// BE sits in the low nibble of byte 4 after a no-op
task automatic branch_op(logic take, word_t a);
   word_t r2;
   word_t exp;
   r2  = take ? a : a ^ 8'h01;
   exp = take ? 8'h31 >> 1 : 8'h05;
   hold_reset();
   load_program(8'h00, a, r2, 8'h31, 8'hF7, 8'hFF, 8'hFF);
   release_reset();
   await_accesses(7, 300);
   compare_value("mem_addr", acc_addr[6], exp);
endtask

task automatic load_and_ref();
   // LDW then STW writes the loaded byte back to the same address
   hold_reset();
   load_program(8'h21, 8'h10, 8'h20, 8'h60, 8'hCD, 8'hFF, 8'hFF);
   release_reset();
   await_writes(1, 400);
   compare_value("mem_addr", wr_addr[0], 8'h60);
   compare_value("mem_wdata", wr_data[0], fill_byte(8'h60));

   // ADD clobbers r0 before REF restores it
   hold_reset();
   load_program(8'h9C, 8'h10, 8'h20, 8'h60, 8'h0E, 8'h45, 8'hDF);
   release_reset();
   await_writes(1, 600);
   compare_value("mem_addr", wr_addr[0], 8'h60);
   compare_value("mem_wdata", wr_data[0], 8'h9C);
endtask

`endif

// ==== testbench/tb_up_core.sv ====
`timescale 1ns/1ns

module tb_up_core;
   import up_pkg::*;

   logic  clk;
   logic  nRst;
   logic  mem_req;
   logic  mem_write;
   word_t mem_addr;
   word_t mem_wdata;
   logic  mem_ack;
   word_t mem_rdata;

   word_t mem [0:255];
   word_t acc_addr[$];    // Every access in the order it was answered
   logic  acc_write[$];
   word_t wr_addr[$];
   word_t wr_data[$];
   int    ack_delay;      // Negative means a random delay of 0 to 3 cycles
   int    delay_left;

   up_core dut (
      .clk       (clk),
      .nRst      (nRst),
      .mem_req   (mem_req),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   `include "up_tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Memory responder that answers on the falling edge
   always @(negedge clk) begin
      if (!nRst) begin
         mem_ack    <= 1'b0;
         delay_left = -1;
      end else if (mem_req && !mem_ack) begin
         if (delay_left < 0)
            delay_left = (ack_delay >= 0) ? ack_delay : $urandom_range(3, 0);
         if (delay_left == 0) begin
            acc_addr.push_back(mem_addr);
            acc_write.push_back(mem_write);
            if (mem_write) begin
               mem[mem_addr] = mem_wdata;
               wr_addr.push_back(mem_addr);
               wr_data.push_back(mem_wdata);
            end else begin
               mem_rdata <= mem[mem_addr];
            end
            mem_ack    <= 1'b1;
            delay_left = -1;
         end else begin
            delay_left = delay_left - 1;
         end
      end else if (!mem_req && mem_ack) begin
         mem_ack <= 1'b0;   // Step 4 of the handshake
      end
   end

   // A failed handshake assertion ends the run at once
   always @(negedge clk) begin
      if (dut.u_port.props.fail_count != 0) begin
         $display("Handshake assertion failed on the memory port at %0t ns", $time);
         stop_run();
      end
   end

   initial begin
      word_t       op_a [0:3];
      word_t       op_b [0:3];
      logic [31:0] seed;
      nRst      = 1'b0;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      ack_delay = -1;
      seed      = $urandom(32'hb6e9);

      boot_order();
      for (int i = 0; i < 4; i++) begin
         op_a[i] = word_t'($urandom);
         op_b[i] = word_t'($urandom);
         arith_op(2'(i), op_a[i], op_b[i]);
      end
      stack_ops(word_t'($urandom), word_t'($urandom));
      branch_op(1'b1, word_t'($urandom));
      branch_op(1'b0, word_t'($urandom));
      load_and_ref();

      // Same operands again with a slow memory
      ack_delay = 6;
      for (int i = 0; i < 4; i++)
         arith_op(2'(i), op_a[i], op_b[i]);

      if (dut.u_port.props.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("Handshake assertions failed %0d times", dut.u_port.props.fail_count);
         stop_run();
      end
   end

endmodule

// ==== filelist.f ====
+incdir+include
logic/up_pkg.sv
logic/reg_bank.sv
logic/ptr_unit.sv
logic/mem_port.sv
logic/seq_control.sv
logic/up_core.sv
testbench/up_core_props.sv
testbench/tb_up_core.sv
